// ==== hdl/core_pkg.sv ====
package core_pkg;

	localparam int M_WIDTH = 32;
	localparam int LG_PRF_ENTRIES = 6;
	localparam int LG_ROB_ENTRIES = 4;
	localparam int LG_PHT_SZ = 8;
	localparam int RAS_DEPTH_LG = 2;

	localparam int RAS_DEPTH = 1 << RAS_DEPTH_LG;	// return stack entries

	typedef logic [M_WIDTH-1:0] addr_t;
	typedef logic [31:0] insn_t;
	typedef logic [LG_PRF_ENTRIES-1:0] preg_t;	// physical register number
	typedef logic [LG_ROB_ENTRIES-1:0] rob_ptr_t;
	typedef logic [LG_PHT_SZ-1:0] pht_idx_t;

endpackage

// ==== hdl/uop_pkg.sv ====
package uop_pkg;

	typedef enum logic [5:0] {
		II,	// illegal
		NOP,
		LB,
		LH,
		LW,
		LBU,
		LHU,
		SB,
		SH,
		SW,
		ADDI,
		SLTI,
		SLTIU,
		XORI,
		ORI,
		ANDI,
		SLLI,
		SRLI,
		SRAI,
		ADDU,
		SUBU,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		MUL,
		MULHU,
		DIV,
		DIVU,
		REM,
		REMU,
		LUI,
		AUIPC,
		BEQ,
		BNE,
		BLT,
		BGE,
		BLTU,
		BGEU,
		J,
		JAL,
		JR,
		JALR,
		RET,
		BREAK,
		MONITOR
	} opcode_t;

	typedef enum logic {
		RUN,
		DRAIN	// waiting for restart
	} dec_state_t;

endpackage

// ==== hdl/decode_riscv.sv ====
`timescale 1ns/1ps

module decode_riscv
	import core_pkg::*, uop_pkg::*;
(
	input insn_t insn,
	input addr_t pc,
	input logic insn_pred,
	input addr_t pred_target,
	input addr_t ras_top,
	output opcode_t op,
	output preg_t src_a,
	output preg_t src_b,
	output preg_t dst,
	output logic src_a_valid,
	output logic src_b_valid,
	output logic dst_valid,
	output logic [31:0] imm,
	output addr_t target,
	output logic br_pred,
	output logic is_br,
	output logic is_mem,
	output logic is_int,
	output logic is_store,
	output logic serializing_op,
	output logic must_restart,
	output logic is_call,
	output logic is_ret
);

	wire [6:0] opcode = insn[6:0];
	wire [2:0] funct3 = insn[14:12];
	wire [6:0] funct7 = insn[31:25];

	preg_t rd;
	preg_t rs1;
	preg_t rs2;
	opcode_t alu_op;	// before the x0 check

	wire [31:0] imm_i = {{20{insn[31]}}, insn[31:20]};
	wire [31:0] imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	wire [31:0] imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
	wire [31:0] imm_u = {insn[31:12], 12'd0};
	wire [31:0] imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

	wire rd_zero = (insn[11:7] == 5'd0);
	wire rd_link = (insn[11:7] == 5'd1) || (insn[11:7] == 5'd5);
	wire rs1_link = (insn[19:15] == 5'd1) || (insn[19:15] == 5'd5);

	assign rd = preg_t'(insn[11:7]);
	assign rs1 = preg_t'(insn[19:15]);
	assign rs2 = preg_t'(insn[24:20]);

	assign is_call = ((op == JAL) || (op == JALR)) && rd_link;
	assign is_ret = (op == RET);

	always_comb
	begin
		op = II;
		alu_op = II;
		src_a = rs1;
		src_b = rs2;
		dst = rd;
		src_a_valid = 1'b0;
		src_b_valid = 1'b0;
		dst_valid = 1'b0;
		imm = 32'd0;
		target = '0;
		br_pred = 1'b0;
		is_br = 1'b0;
		is_mem = 1'b0;
		is_int = 1'b0;
		is_store = 1'b0;
		serializing_op = 1'b0;
		must_restart = 1'b0;

		case (opcode)
			7'h03:
			begin
				src_a_valid = !rd_zero;
				dst_valid = !rd_zero;
				is_mem = 1'b1;
				imm = imm_i;
				case (funct3)
					3'd0: alu_op = LB;
					3'd1: alu_op = LH;
					3'd2: alu_op = LW;
					3'd4: alu_op = LBU;
					3'd5: alu_op = LHU;
					default: alu_op = II;
				endcase
				op = (rd_zero && alu_op != II) ? NOP : alu_op;
			end
			7'h0f: op = NOP;	// fence
			7'h13:
			begin
				src_a_valid = !rd_zero;
				dst_valid = !rd_zero;
				is_int = 1'b1;
				imm = imm_i;
				case (funct3)
					3'd0: alu_op = ADDI;
					3'd1: alu_op = (funct7 == 7'h00) ? SLLI : II;
					3'd2: alu_op = SLTI;
					3'd3: alu_op = SLTIU;
					3'd4: alu_op = XORI;
					3'd5: alu_op = (funct7 == 7'h00) ? SRLI : ((funct7 == 7'h20) ? SRAI : II);
					3'd6: alu_op = ORI;
					default: alu_op = ANDI;
				endcase
				op = (rd_zero && alu_op != II) ? NOP : alu_op;
			end
			7'h17:
			begin
				op = rd_zero ? NOP : AUIPC;
				dst_valid = !rd_zero;
				is_int = 1'b1;
				imm = imm_u;
			end
			7'h23:
			begin
				src_a_valid = 1'b1;
				src_b_valid = 1'b1;
				is_mem = 1'b1;
				is_store = 1'b1;
				imm = imm_s;
				case (funct3)
					3'd0: op = SB;
					3'd1: op = SH;
					3'd2: op = SW;
					default: op = II;
				endcase
			end
			7'h33:
			begin
				src_a_valid = 1'b1;
				src_b_valid = 1'b1;
				dst_valid = !rd_zero;
				is_int = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: alu_op = ADDU;
					10'b0100000_000: alu_op = SUBU;
					10'b0000000_001: alu_op = SLL;
					10'b0000000_010: alu_op = SLT;
					10'b0000000_011: alu_op = SLTU;
					10'b0000000_100: alu_op = XOR;
					10'b0000000_101: alu_op = SRL;
					10'b0100000_101: alu_op = SRA;
					10'b0000000_110: alu_op = OR;
					10'b0000000_111: alu_op = AND;
					10'b0000001_000: alu_op = MUL;
					10'b0000001_011: alu_op = MULHU;
					10'b0000001_100: alu_op = DIV;
					10'b0000001_101: alu_op = DIVU;
					10'b0000001_110: alu_op = REM;
					10'b0000001_111: alu_op = REMU;
					default: alu_op = II;
				endcase
				op = (rd_zero && alu_op != II) ? NOP : alu_op;
			end
			7'h37:
			begin
				op = rd_zero ? NOP : LUI;
				dst_valid = !rd_zero;
				is_int = 1'b1;
				imm = imm_u;
			end
			7'h63:
			begin
				src_a_valid = 1'b1;
				src_b_valid = 1'b1;
				is_int = 1'b1;
				is_br = 1'b1;
				br_pred = insn_pred;
				imm = imm_b;
				target = pc + imm_b;
				case (funct3)
					3'd0: op = BEQ;
					3'd1: op = BNE;
					3'd4: op = BLT;
					3'd5: op = BGE;
					3'd6: op = BLTU;
					3'd7: op = BGEU;
					default: op = II;
				endcase
			end
			7'h67:
			begin
				src_a_valid = 1'b1;
				is_int = 1'b1;
				is_br = 1'b1;
				br_pred = 1'b1;
				imm = imm_i;
				target = pred_target;
				if (funct3 != 3'd0)
					op = II;
				else if (!rd_zero)
				begin
					op = JALR;
					dst_valid = 1'b1;
				end
				else if (rs1_link)
				begin
					op = RET;
					target = ras_top;	// stack beats the btb
				end
				else
					op = JR;
			end
			7'h6f:
			begin
				op = rd_zero ? J : JAL;
				dst_valid = !rd_zero;
				is_int = 1'b1;
				is_br = 1'b1;
				br_pred = 1'b1;
				imm = imm_j;
				target = pc + imm_j;
			end
			7'h73:
			begin
				is_int = 1'b1;
				if (insn[31:7] == 25'd0)
				begin
					op = BREAK;
					serializing_op = 1'b1;
				end
				else if (insn[31:20] == 12'd1 && insn[19:7] == 13'd0)
				begin
					op = MONITOR;
					serializing_op = 1'b1;
					must_restart = 1'b1;
				end
				else
					op = NOP;	// csr ops ignored
			end
			default: op = II;
		endcase

		if (op == II)
		begin
			src_a_valid = 1'b0;
			src_b_valid = 1'b0;
			dst_valid = 1'b0;
		end
	end

endmodule

// ==== hdl/return_stack.sv ====
`timescale 1ns/1ps

module return_stack
	import core_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic push,
	input logic pop,
	input addr_t push_addr,
	output addr_t top
);

	logic [RAS_DEPTH_LG-1:0] ptr;
	addr_t stack [RAS_DEPTH];

	wire [RAS_DEPTH_LG-1:0] ptr_inc = ptr + 1'b1;

	assign top = stack[ptr];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ptr <= '0;
			for (int i = 0; i < RAS_DEPTH; i++)
				stack[i] <= '0;
		end
		else if (push)
		begin
			ptr <= ptr_inc;	// wraps, oldest entry lost
			stack[ptr_inc] <= push_addr;
		end
		else if (pop)
			ptr <= ptr - 1'b1;
	end

	// a single decoded op is never both a call and a return
	a_no_push_pop: assert property (@(posedge clk) disable iff (!arst_n)
		!(push && pop));

endmodule

// ==== hdl/decode_ctrl.sv ====
`timescale 1ns/1ps

module decode_ctrl
	import core_pkg::*, uop_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic restart,
	input opcode_t op,
	input preg_t src_a,
	input preg_t src_b,
	input preg_t dst,
	input logic src_a_valid,
	input logic src_b_valid,
	input logic dst_valid,
	input logic [31:0] imm,
	input addr_t target,
	input logic br_pred,
	input logic is_br,
	input logic is_mem,
	input logic is_int,
	input logic is_store,
	input logic serializing_op,
	input logic must_restart,
	input logic is_call,
	input logic is_ret,
	input addr_t pc,
	input pht_idx_t pht_idx,
	output logic uop_valid,
	output opcode_t uop_op,
	output preg_t uop_src_a,
	output preg_t uop_src_b,
	output preg_t uop_dst,
	output logic uop_src_a_valid,
	output logic uop_src_b_valid,
	output logic uop_dst_valid,
	output logic [31:0] uop_imm,
	output addr_t uop_target,
	output logic uop_br_pred,
	output logic uop_is_br,
	output logic uop_is_mem,
	output logic uop_is_int,
	output logic uop_is_store,
	output logic uop_serializing_op,
	output logic uop_must_restart,
	output addr_t uop_pc,
	output pht_idx_t uop_pht_idx,
	output rob_ptr_t rob_ptr,
	output logic ras_push,
	output logic ras_pop,
	output addr_t ras_push_addr
);

	dec_state_t state;
	dec_state_t state_nxt;
	rob_ptr_t rob_cnt;	// next free rob slot

	wire accept = in_valid && (state == RUN);

	assign ras_push = accept && is_call;
	assign ras_pop = accept && is_ret;
	assign ras_push_addr = pc + 32'd4;	// return lands after the call

	always_comb
	begin
		state_nxt = state;
		case (state)
			RUN:
				if (accept && serializing_op)
					state_nxt = DRAIN;
			default:
				if (restart)
					state_nxt = RUN;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= RUN;
			uop_valid <= 1'b0;
			rob_cnt <= '0;
		end
		else
		begin
			state <= state_nxt;
			uop_valid <= accept;
			if (accept)
				rob_cnt <= rob_cnt + 1'b1;	// wraps at rob size
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			uop_op <= op;
			uop_src_a <= src_a;
			uop_src_b <= src_b;
			uop_dst <= dst;
			uop_src_a_valid <= src_a_valid;
			uop_src_b_valid <= src_b_valid;
			uop_dst_valid <= dst_valid;
			uop_imm <= imm;
			uop_target <= target;
			uop_br_pred <= br_pred;
			uop_is_br <= is_br;
			uop_is_mem <= is_mem;
			uop_is_int <= is_int;
			uop_is_store <= is_store;
			uop_serializing_op <= serializing_op;
			uop_must_restart <= must_restart;
			uop_pc <= pc;
			uop_pht_idx <= pht_idx;
			rob_ptr <= rob_cnt;
		end
	end

	// the strobe right after a serializing op never issues
	a_drop_no_uop: assert property (@(posedge clk) disable iff (!arst_n)
		(uop_valid && uop_serializing_op) |=> !uop_valid);

	// fetch only restarts after a serializing op
	a_restart_in_drain: assert property (@(posedge clk) disable iff (!arst_n)
		restart |-> (state == DRAIN));

endmodule

// ==== hdl/decode_top.sv ====
`timescale 1ns/1ps

module decode_top
	import core_pkg::*, uop_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic restart,
	input insn_t insn,
	input addr_t pc,
	input logic insn_pred,
	input pht_idx_t pht_idx,
	input addr_t pred_target,
	output logic uop_valid,
	output opcode_t uop_op,
	output preg_t uop_src_a,
	output preg_t uop_src_b,
	output preg_t uop_dst,
	output logic uop_src_a_valid,
	output logic uop_src_b_valid,
	output logic uop_dst_valid,
	output logic [31:0] uop_imm,
	output addr_t uop_target,
	output logic uop_br_pred,
	output logic uop_is_br,
	output logic uop_is_mem,
	output logic uop_is_int,
	output logic uop_is_store,
	output logic uop_serializing_op,
	output logic uop_must_restart,
	output addr_t uop_pc,
	output pht_idx_t uop_pht_idx,
	output rob_ptr_t rob_ptr
);

	opcode_t op;
	preg_t src_a;
	preg_t src_b;
	preg_t dst;
	logic src_a_valid;
	logic src_b_valid;
	logic dst_valid;
	logic [31:0] imm;
	addr_t target;
	logic br_pred;
	logic is_br;
	logic is_mem;
	logic is_int;
	logic is_store;
	logic serializing_op;
	logic must_restart;
	logic is_call;
	logic is_ret;
	addr_t ras_top;
	logic ras_push;
	logic ras_pop;
	addr_t ras_push_addr;

	decode_riscv u_dec (.*);	// names match port for port

	decode_ctrl u_ctrl (.*);

	return_stack u_ras (
		.clk(clk),
		.arst_n(arst_n),
		.push(ras_push),
		.pop(ras_pop),
		.push_addr(ras_push_addr),
		.top(ras_top)
	);

endmodule

// ==== dv/decode_ref.svh ====
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

addr_t ras_m [4];	// return stack copy
logic [1:0] ras_sp_m;
rob_ptr_t rob_m;
logic drain_m;
logic exp_valid;
opcode_t exp_op;
preg_t exp_src_a;
preg_t exp_src_b;
preg_t exp_dst;
logic exp_a_v;
logic exp_b_v;
logic exp_d_v;
logic [31:0] exp_imm;
addr_t exp_target;
logic exp_br_pred;
logic exp_is_br;
logic exp_is_mem;
logic exp_is_int;
logic exp_is_store;
logic exp_ser;
logic exp_must_restart;
addr_t exp_pc;
pht_idx_t exp_pht_idx;
rob_ptr_t exp_rob_ptr;
logic exp_call;
logic exp_ret;

task automatic model_reset();
	for (int i = 0; i < 4; i++)
		ras_m[i] = '0;
	ras_sp_m = '0;
	rob_m = '0;
	drain_m = 1'b0;
	exp_valid = 1'b0;
endtask

task automatic ref_decode(input insn_t w, input addr_t p, input logic pred, input addr_t ptgt,
		input addr_t top);
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [2:0] f3;
	logic [6:0] f7;
	logic nop_x0;	// rd == x0 turns a legal op into NOP
	rd = w[11:7];
	rs1 = w[19:15];
	f3 = w[14:12];
	f7 = w[31:25];
	nop_x0 = 1'b0;
	exp_op = II;
	exp_src_a = {1'b0, rs1};
	exp_src_b = {1'b0, w[24:20]};
	exp_dst = {1'b0, rd};
	exp_a_v = 1'b0;
	exp_b_v = 1'b0;
	exp_d_v = 1'b0;
	exp_imm = '0;
	exp_target = '0;
	exp_br_pred = 1'b0;
	exp_is_br = 1'b0;
	exp_is_mem = 1'b0;
	exp_is_int = 1'b0;
	exp_is_store = 1'b0;
	exp_ser = 1'b0;
	exp_must_restart = 1'b0;
	case (w[6:0])
		7'h03:
		begin
			nop_x0 = 1'b1;
			exp_is_mem = 1'b1;
			exp_a_v = (rd != 5'd0);
			exp_d_v = (rd != 5'd0);
			exp_imm = {{20{w[31]}}, w[31:20]};
			case (f3)
				3'd0: exp_op = LB;
				3'd1: exp_op = LH;
				3'd2: exp_op = LW;
				3'd4: exp_op = LBU;
				3'd5: exp_op = LHU;
				default: exp_op = II;
			endcase
		end
		7'h0f: exp_op = NOP;
		7'h13:
		begin
			nop_x0 = 1'b1;
			exp_is_int = 1'b1;
			exp_a_v = (rd != 5'd0);
			exp_d_v = (rd != 5'd0);
			exp_imm = {{20{w[31]}}, w[31:20]};
			case (f3)
				3'd0: exp_op = ADDI;
				3'd2: exp_op = SLTI;
				3'd3: exp_op = SLTIU;
				3'd4: exp_op = XORI;
				3'd6: exp_op = ORI;
				3'd7: exp_op = ANDI;
				3'd1: exp_op = (f7 == 7'h00) ? SLLI : II;
				default: exp_op = (f7 == 7'h00) ? SRLI : (f7 == 7'h20) ? SRAI : II;
			endcase
		end
		7'h17, 7'h37:
		begin
			nop_x0 = 1'b1;
			exp_op = w[5] ? LUI : AUIPC;
			exp_is_int = 1'b1;
			exp_d_v = (rd != 5'd0);
			exp_imm = {w[31:12], 12'h000};
		end
		7'h23:
		begin
			exp_is_mem = 1'b1;
			exp_is_store = 1'b1;
			exp_a_v = 1'b1;
			exp_b_v = 1'b1;
			exp_imm = {{20{w[31]}}, w[31:25], w[11:7]};
			exp_op = (f3 == 3'd0) ? SB : (f3 == 3'd1) ? SH : (f3 == 3'd2) ? SW : II;
		end
		7'h33:
		begin
			nop_x0 = 1'b1;
			exp_is_int = 1'b1;
			exp_a_v = 1'b1;
			exp_b_v = 1'b1;
			exp_d_v = (rd != 5'd0);
			case (f7)
				7'h00:
				case (f3)
					3'd0: exp_op = ADDU;
					3'd1: exp_op = SLL;
					3'd2: exp_op = SLT;
					3'd3: exp_op = SLTU;
					3'd4: exp_op = XOR;
					3'd5: exp_op = SRL;
					3'd6: exp_op = OR;
					default: exp_op = AND;
				endcase
				7'h20: exp_op = (f3 == 3'd0) ? SUBU : (f3 == 3'd5) ? SRA : II;
				7'h01:
				case (f3)
					3'd0: exp_op = MUL;
					3'd3: exp_op = MULHU;
					3'd4: exp_op = DIV;
					3'd5: exp_op = DIVU;
					3'd6: exp_op = REM;
					3'd7: exp_op = REMU;
					default: exp_op = II;	// mulh and mulhsu not supported
				endcase
				default: exp_op = II;
			endcase
		end
		7'h63:
		begin
			exp_is_int = 1'b1;
			exp_is_br = 1'b1;
			exp_br_pred = pred;
			exp_a_v = 1'b1;
			exp_b_v = 1'b1;
			exp_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			exp_target = p + exp_imm;
			case (f3)
				3'd0: exp_op = BEQ;
				3'd1: exp_op = BNE;
				3'd4: exp_op = BLT;
				3'd5: exp_op = BGE;
				3'd6: exp_op = BLTU;
				3'd7: exp_op = BGEU;
				default: exp_op = II;
			endcase
		end
		7'h67:
		begin
			exp_is_int = 1'b1;
			exp_is_br = 1'b1;
			exp_br_pred = 1'b1;
			exp_a_v = 1'b1;
			exp_imm = {{20{w[31]}}, w[31:20]};
			exp_target = ptgt;
			if (f3 != 3'd0)
				exp_op = II;
			else if (rd != 5'd0)
			begin
				exp_op = JALR;
				exp_d_v = 1'b1;
			end
			else if (rs1 == 5'd1 || rs1 == 5'd5)
			begin
				exp_op = RET;
				exp_target = top;
			end
			else
				exp_op = JR;
		end
		7'h6f:
		begin
			exp_op = (rd == 5'd0) ? J : JAL;
			exp_is_int = 1'b1;
			exp_is_br = 1'b1;
			exp_br_pred = 1'b1;
			exp_d_v = (rd != 5'd0);
			exp_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			exp_target = p + exp_imm;
		end
		7'h73:
		begin
			exp_is_int = 1'b1;
			exp_op = NOP;
			exp_ser = (w == 32'h0000_0073) || (w == 32'h0010_0073);
			exp_must_restart = (w == 32'h0010_0073);
			if (exp_ser)
				exp_op = exp_must_restart ? MONITOR : BREAK;
		end
		default: exp_op = II;
	endcase
	if (exp_op == II)
	begin
		exp_a_v = 1'b0;
		exp_b_v = 1'b0;
		exp_d_v = 1'b0;
	end
	else if (nop_x0 && rd == 5'd0)
		exp_op = NOP;
	exp_call = (exp_op == JAL || exp_op == JALR) && (rd == 5'd1 || rd == 5'd5);
	exp_ret = (exp_op == RET);
endtask

// one cycle of the control model, called with the inputs seen at the next edge
task automatic model_step(input logic v, input logic rst, input insn_t w, input addr_t p,
		input logic pred, input pht_idx_t idx, input addr_t ptgt);
	exp_valid = v && !drain_m;
	if (exp_valid)
	begin
		ref_decode(w, p, pred, ptgt, ras_m[ras_sp_m]);
		exp_pc = p;
		exp_pht_idx = idx;
		exp_rob_ptr = rob_m;
		rob_m = rob_m + 4'd1;
		if (exp_call)
		begin
			ras_sp_m = ras_sp_m + 2'd1;
			ras_m[ras_sp_m] = p + 32'd4;
		end
		else if (exp_ret)
			ras_sp_m = ras_sp_m - 2'd1;
		if (exp_ser)
			drain_m = 1'b1;
	end
	else if (drain_m && rst)
		drain_m = 1'b0;
endtask

`endif

// ==== dv/tb_decode.sv ====
`timescale 1ns/1ps

module tb_decode
	import core_pkg::*, uop_pkg::*;
();

	localparam int STIM_CYCLES = 2000;
	localparam int TIMEOUT_CYCLES = 3000;	// random part plus reset and directed margin

	logic clk;
	logic arst_n;
	logic in_valid;
	logic restart;
	insn_t insn;
	addr_t pc;
	logic insn_pred;
	pht_idx_t pht_idx;
	addr_t pred_target;
	logic uop_valid;
	opcode_t uop_op;
	preg_t uop_src_a;
	preg_t uop_src_b;
	preg_t uop_dst;
	logic uop_src_a_valid;
	logic uop_src_b_valid;
	logic uop_dst_valid;
	logic [31:0] uop_imm;
	addr_t uop_target;
	logic uop_br_pred;
	logic uop_is_br;
	logic uop_is_mem;
	logic uop_is_int;
	logic uop_is_store;
	logic uop_serializing_op;
	logic uop_must_restart;
	addr_t uop_pc;
	pht_idx_t uop_pht_idx;
	rob_ptr_t rob_ptr;

	integer seed = 32'hee15;
	int errors = 0;
	int checked = 0;
	int cycles = 0;

	`include "decode_ref.svh"

	decode_top u_dut (.*);

	initial
		clk = 1'b0;

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
		begin
			$display("run stopped by timeout after %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d, uops checked: %0d", errors, checked);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic compare_outputs();
		if (exp_valid && !uop_valid)
		begin
			$display("uop_valid missing after an accepted instruction at %0t", $time);
			errors++;
		end
		else if (!exp_valid && uop_valid)
		begin
			$display("uop_valid high without an accepted instruction at %0t", $time);
			errors++;
		end
		else if (exp_valid)
		begin
			checked++;
			check_val("uop_op", 32'(uop_op), 32'(exp_op));
			check_val("uop_src_a", 32'(uop_src_a), 32'(exp_src_a));
			check_val("uop_src_b", 32'(uop_src_b), 32'(exp_src_b));
			check_val("uop_dst", 32'(uop_dst), 32'(exp_dst));
			check_val("uop_src_a_valid", 32'(uop_src_a_valid), 32'(exp_a_v));
			check_val("uop_src_b_valid", 32'(uop_src_b_valid), 32'(exp_b_v));
			check_val("uop_dst_valid", 32'(uop_dst_valid), 32'(exp_d_v));
			check_val("uop_imm", uop_imm, exp_imm);
			check_val("uop_target", uop_target, exp_target);
			check_val("uop_br_pred", 32'(uop_br_pred), 32'(exp_br_pred));
			check_val("uop_is_br", 32'(uop_is_br), 32'(exp_is_br));
			check_val("uop_is_mem", 32'(uop_is_mem), 32'(exp_is_mem));
			check_val("uop_is_int", 32'(uop_is_int), 32'(exp_is_int));
			check_val("uop_is_store", 32'(uop_is_store), 32'(exp_is_store));
			check_val("uop_serializing_op", 32'(uop_serializing_op), 32'(exp_ser));
			check_val("uop_must_restart", 32'(uop_must_restart), 32'(exp_must_restart));
			check_val("uop_pc", uop_pc, exp_pc);
			check_val("uop_pht_idx", 32'(uop_pht_idx), 32'(exp_pht_idx));
			check_val("rob_ptr", 32'(rob_ptr), 32'(exp_rob_ptr));
		end
	endtask

	// weighted instruction classes with random fields
	task automatic build_insn(output insn_t w);
		int cls;
		logic [31:0] r;
		logic [31:0] s;
		logic [4:0] rd;
		logic [4:0] link;
		logic [4:0] jrd;
		logic [6:0] f7;
		r = $random(seed);
		s = $random(seed);
		cls = int'(s[31:8] % 24'd100);
		rd = (s[2:0] == 3'd0) ? 5'd0 : r[11:7];	// x0 about one in eight
		link = s[3] ? 5'd1 : 5'd5;
		jrd = (s[7:6] == 2'd0) ? 5'd0 : (s[7:6] == 2'd1) ? link : rd;
		case (s[5:4])
			2'd0: f7 = 7'h00;
			2'd1: f7 = 7'h20;
			2'd2: f7 = 7'h01;
			default: f7 = r[31:25];
		endcase
		if (cls < 16)
			w = {f7, r[24:12], rd, 7'h13};
		else if (cls < 32)
			w = {f7, r[24:12], rd, 7'h33};
		else if (cls < 42)
			w = {r[31:12], rd, 7'h03};
		else if (cls < 50)
			w = {r[31:15], 1'b0, r[13:7], 7'h23};
		else if (cls < 56)
			w = {r[31:12], rd, (s[6] ? 7'h37 : 7'h17)};
		else if (cls < 66)
			w = {r[31:7], 7'h63};
		else if (cls < 74)
			w = {r[31:12], (s[6] ? link : rd), 7'h6f};
		else if (cls < 86)
			w = {r[31:20], (s[9] ? link : r[19:15]), (s[11:10] == 2'd3 ? r[14:12] : 3'd0),
				jrd, 7'h67};
		else if (cls < 90)
			w = s[6] ? 32'h0000_0073 : (s[7] ? 32'h0010_0073 : {r[31:7], 7'h73});
		else if (cls < 93)
			w = {r[31:7], 7'h0f};
		else
			w = r;	// mostly illegal opcodes
	endtask

	// check the last cycle's result, then drive the next one
	task automatic step(input logic v, input logic rst, input insn_t w, input addr_t p,
			input logic pred, input pht_idx_t idx, input addr_t ptgt);
		@(posedge clk);
		#1;
		compare_outputs();
		in_valid = v;
		restart = rst;
		insn = w;
		pc = p;
		insn_pred = pred;
		pht_idx = idx;
		pred_target = ptgt;
		model_step(v, rst, w, p, pred, idx, ptgt);
	endtask

	initial
	begin
		insn_t w;
		addr_t pc_r;
		logic v;
		logic rst;
		in_valid = 1'b0;
		restart = 1'b0;
		insn = '0;
		pc = '0;
		insn_pred = 1'b0;
		pht_idx = '0;
		pred_target = '0;
		arst_n = 1'b0;
		pc_r = 32'h0000_1000;
		model_reset();
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// six nested calls then six returns, two deeper than the stack
		for (int i = 0; i < 6; i++)
			step(1'b1, 1'b0, {20'h00800, 5'd1, 7'h6f}, 32'h0000_2000 + 32'(i) * 32'h100,
				1'b0, 8'(i), 32'h0);
		for (int i = 0; i < 6; i++)
			step(1'b1, 1'b0, 32'h0000_8067, 32'h0000_3000 + 32'(i) * 32'h4,
				1'b1, 8'(i), 32'hdead_0000);

		// monitor, a dropped strobe, restart with a dropped strobe, then addi
		step(1'b1, 1'b0, 32'h0010_0073, 32'h0000_4000, 1'b0, 8'h10, 32'h0);
		step(1'b1, 1'b0, 32'h0010_8093, 32'h0000_4004, 1'b0, 8'h11, 32'h0);
		step(1'b1, 1'b1, 32'h0010_8093, 32'h0000_4004, 1'b0, 8'h12, 32'h0);
		step(1'b1, 1'b0, 32'h0010_8093, 32'h0000_4004, 1'b0, 8'h13, 32'h0);

		for (int n = 0; n < STIM_CYCLES; n++)
		begin
			v = (($random(seed) & 3) != 0);
			rst = drain_m && (($random(seed) & 3) == 0);
			build_insn(w);
			if (($random(seed) & 31) == 0)
				pc_r = addr_t'($random(seed)) & 32'hffff_fffc;
			step(v, rst, w, pc_r, 1'($random(seed)), 8'($random(seed)),
				addr_t'($random(seed)) & 32'hffff_fffc);
			if (v)
				pc_r = pc_r + 32'd4;
		end
		step(1'b0, 1'b0, '0, '0, 1'b0, '0, '0);	// picks up the last uop

		$display("errors: %0d, uops checked: %0d", errors, checked);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== decode_subsys.f ====
+incdir+dv
hdl/core_pkg.sv
hdl/uop_pkg.sv
hdl/decode_riscv.sv
hdl/return_stack.sv
hdl/decode_ctrl.sv
hdl/decode_top.sv
dv/tb_decode.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f decode_subsys.f \
	--top-module tb_decode -o tb_decode \
	&& ./obj_dir/tb_decode > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation completed successfully$" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
